// File: hw/wb_access.sv
`timescale 1ns/1ns

module wb_access (
    input  logic                  clk,
    input  logic                  rst,
    wb_req_if.bus                 wb,
    output xfcp_wb_pkg::wb_addr_t wb_adr_o,
    output xfcp_wb_pkg::wb_data_t wb_dat_o,
    input  xfcp_wb_pkg::wb_data_t wb_dat_i,
    output logic                  wb_we_o,
    output xfcp_wb_pkg::wb_sel_t  wb_sel_o,
    output logic                  wb_stb_o,
    output logic                  wb_cyc_o,
    input  logic                  wb_ack_i,
    input  logic                  wb_err_i
);

    logic stb_q, cyc_q, done_q;
    xfcp_wb_pkg::wb_data_t rdata_q;

    // word aligned, the lane is carried by the byte selects
    assign wb_adr_o = wb.addr & ~xfcp_wb_pkg::wb_addr_t'(xfcp_wb_pkg::WORD_BYTES - 1);
    assign wb_dat_o = wb.wdata;
    assign wb_sel_o = wb.sel;
    assign wb_we_o = wb.we;
    assign wb_stb_o = stb_q;
    assign wb_cyc_o = cyc_q;
    assign wb.done = done_q;
    assign wb.rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            stb_q <= 1'b0;
            cyc_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (wb.start) begin
                stb_q <= 1'b1;
                cyc_q <= 1'b1;
            end else if (stb_q && (wb_ack_i || wb_err_i)) begin
                stb_q <= 1'b0;
                done_q <= 1'b1;
            end else if (cyc_q && !stb_q && !done_q) begin
                // quiet cycle after done, release the bus
                cyc_q <= 1'b0;
            end
        end
        if (stb_q && (wb_ack_i || wb_err_i)) begin
            rdata_q <= wb_dat_i;
        end
    end

    stb_within_cyc: assert property (
        @(posedge clk) disable iff (rst) wb_stb_o |-> wb_cyc_o
    );

    // the controller waits for done before the next access
    no_start_in_flight: assert property (
        @(posedge clk) disable iff (rst) wb.start |-> !stb_q
    );

endmodule

// File: hw/wb_req_if.sv
`timescale 1ns/1ns

interface wb_req_if;
    logic                  start;
    logic                  we;
    xfcp_wb_pkg::wb_addr_t addr;
    xfcp_wb_pkg::wb_data_t wdata;
    xfcp_wb_pkg::wb_sel_t  sel;
    logic                  done;
    xfcp_wb_pkg::wb_data_t rdata;

    // request side, holds addr/wdata/sel until done
    modport ctrl (
        output start, we, addr, wdata, sel,
        input  done, rdata
    );

    // bus cycle engine side
    modport bus (
        input  start, we, addr, wdata, sel,
        output done, rdata
    );
endinterface

// File: hw/xfcp_ctrl.sv
`timescale 1ns/1ns

module xfcp_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  xfcp_wb_pkg::byte_t in_tdata_i,
    input  logic               in_tvalid_i,
    input  logic               in_tlast_i,
    output logic               in_tready_o,
    xfcp_stream_if.src         tx,
    wb_req_if.ctrl             wb
);

    xfcp_wb_pkg::ctrl_state_t state_q, state_d;
    logic in_ready_q, in_ready_d;
    logic tx_ready_q;
    logic last_q, last_d;
    logic in_fire;
    // ready source: own value or the early ready of the skid register
    logic rdy_own, rdy_val;
    logic [2:0] hdr_cnt_q, hdr_cnt_d;
    logic [$clog2(xfcp_wb_pkg::ID_LEN)-1:0] id_ptr_q, id_ptr_d;
    logic [$clog2(xfcp_wb_pkg::WORD_BYTES)-1:0] lane_q, lane_d;
    logic we_q, we_d;
    xfcp_wb_pkg::wb_addr_t addr_q, addr_d;
    xfcp_wb_pkg::count_t count_q, count_d, count_hdr;
    xfcp_wb_pkg::wb_data_t data_q, data_d;
    xfcp_wb_pkg::wb_sel_t sel_q, sel_d;

    assign in_tready_o = in_ready_q;
    assign in_fire = in_ready_q && in_tvalid_i;
    assign last_d = in_fire ? in_tlast_i : last_q;
    assign in_ready_d = rdy_own ? rdy_val : tx.tready_early;
    // count field as completed by the current header byte
    assign count_hdr = xfcp_wb_pkg::count_t'({count_q, in_tdata_i});

    assign wb.we = we_q;
    assign wb.addr = addr_q;
    assign wb.wdata = data_q;
    assign wb.sel = sel_q;

    always_comb begin
        state_d = state_q;
        rdy_own = 1'b0;
        rdy_val = 1'b1;
        hdr_cnt_d = hdr_cnt_q;
        id_ptr_d = id_ptr_q;
        lane_d = lane_q;
        we_d = we_q;
        addr_d = addr_q;
        count_d = count_q;
        data_d = data_q;
        sel_d = sel_q;
        tx.tdata = in_tdata_i;
        tx.tvalid = 1'b0;
        tx.tlast = 1'b0;
        tx.tuser = 1'b0;
        wb.start = 1'b0;

        case (state_q)
            xfcp_wb_pkg::ST_IDLE: begin
                if (in_fire) begin
                    if (in_tdata_i == xfcp_wb_pkg::START_TAG) begin
                        // echo the tag, a lone tag counts as a cut header
                        tx.tvalid = 1'b1;
                        tx.tlast = in_tlast_i;
                        tx.tuser = in_tlast_i;
                        state_d = in_tlast_i ? xfcp_wb_pkg::ST_IDLE : xfcp_wb_pkg::ST_TYPE;
                    end else if (!in_tlast_i) begin
                        state_d = xfcp_wb_pkg::ST_DROP;
                    end
                end
            end

            xfcp_wb_pkg::ST_TYPE: begin
                if (in_fire) begin
                    tx.tvalid = 1'b1;
                    hdr_cnt_d = '0;
                    id_ptr_d = '0;
                    if (in_tdata_i == xfcp_wb_pkg::READ_REQ && !in_tlast_i) begin
                        tx.tdata = xfcp_wb_pkg::READ_RESP;
                        we_d = 1'b0;
                        state_d = xfcp_wb_pkg::ST_HEADER;
                    end else if (in_tdata_i == xfcp_wb_pkg::WRITE_REQ && !in_tlast_i) begin
                        tx.tdata = xfcp_wb_pkg::WRITE_RESP;
                        we_d = 1'b1;
                        state_d = xfcp_wb_pkg::ST_HEADER;
                    end else if (in_tdata_i == xfcp_wb_pkg::ID_REQ) begin
                        tx.tdata = xfcp_wb_pkg::ID_RESP;
                        rdy_own = 1'b1;
                        rdy_val = !last_d;
                        state_d = xfcp_wb_pkg::ST_ID_SEND;
                    end else begin
                        // unknown type, or read/write cut after its type byte
                        tx.tlast = 1'b1;
                        tx.tuser = 1'b1;
                        state_d = in_tlast_i ? xfcp_wb_pkg::ST_IDLE : xfcp_wb_pkg::ST_DROP;
                    end
                end
            end

            xfcp_wb_pkg::ST_HEADER: begin
                if (in_fire) begin
                    tx.tvalid = 1'b1;
                    hdr_cnt_d = hdr_cnt_q + 3'd1;
                    // address first, then count, both msb first
                    if (hdr_cnt_q < 3'(xfcp_wb_pkg::ADDR_BYTES)) begin
                        addr_d = xfcp_wb_pkg::wb_addr_t'({addr_q, in_tdata_i});
                    end else begin
                        count_d = count_hdr;
                    end
                    if (hdr_cnt_q == 3'(xfcp_wb_pkg::ADDR_BYTES + xfcp_wb_pkg::COUNT_BYTES - 1))
                    begin
                        lane_d = addr_q[$bits(lane_q)-1:0];
                        data_d = '0;
                        sel_d = '0;
                        if (we_q || count_hdr == '0) begin
                            // write echo ends here, as does an empty read
                            tx.tlast = 1'b1;
                            if (in_tlast_i) begin
                                state_d = xfcp_wb_pkg::ST_IDLE;
                            end else begin
                                rdy_own = 1'b1;
                                state_d = (we_q && count_hdr != '0) ?
                                    xfcp_wb_pkg::ST_WRITE_TAKE : xfcp_wb_pkg::ST_DROP;
                            end
                        end else begin
                            wb.start = 1'b1;
                            rdy_own = 1'b1;
                            rdy_val = !last_d;
                            state_d = xfcp_wb_pkg::ST_READ_WAIT;
                        end
                    end else if (in_tlast_i) begin
                        tx.tlast = 1'b1;
                        tx.tuser = 1'b1;
                        state_d = xfcp_wb_pkg::ST_IDLE;
                    end
                end
            end

            xfcp_wb_pkg::ST_READ_WAIT: begin
                // trailing request bytes are drained meanwhile
                rdy_own = 1'b1;
                rdy_val = !last_d;
                if (wb.done) begin
                    data_d = wb.rdata;
                    addr_d = addr_q + xfcp_wb_pkg::wb_addr_t'(xfcp_wb_pkg::WORD_BYTES);
                    state_d = xfcp_wb_pkg::ST_READ_SEND;
                end
            end

            xfcp_wb_pkg::ST_READ_SEND: begin
                rdy_own = 1'b1;
                rdy_val = !last_d;
                if (tx_ready_q) begin
                    tx.tvalid = 1'b1;
                    tx.tdata = data_q[8*lane_q +: 8];
                    lane_d = lane_q + 1'b1;
                    count_d = count_q - 1'b1;
                    if (count_q == xfcp_wb_pkg::count_t'(1)) begin
                        tx.tlast = 1'b1;
                        rdy_own = !last_d;
                        state_d = last_d ? xfcp_wb_pkg::ST_IDLE : xfcp_wb_pkg::ST_DROP;
                    end else if (lane_q == '1) begin
                        wb.start = 1'b1;
                        state_d = xfcp_wb_pkg::ST_READ_WAIT;
                    end
                end
            end

            xfcp_wb_pkg::ST_WRITE_TAKE: begin
                rdy_own = 1'b1;
                if (in_fire) begin
                    data_d[8*lane_q +: 8] = in_tdata_i;
                    sel_d[lane_q] = 1'b1;
                    lane_d = lane_q + 1'b1;
                    // input tlast ends the write after this word
                    count_d = in_tlast_i ? '0 : count_q - 1'b1;
                    if (lane_q == '1 || count_q == xfcp_wb_pkg::count_t'(1) || in_tlast_i) begin
                        wb.start = 1'b1;
                        rdy_val = 1'b0;
                        state_d = xfcp_wb_pkg::ST_WRITE_WAIT;
                    end
                end
            end

            xfcp_wb_pkg::ST_WRITE_WAIT: begin
                rdy_own = 1'b1;
                rdy_val = 1'b0;
                if (wb.done) begin
                    data_d = '0;
                    sel_d = '0;
                    addr_d = addr_q + xfcp_wb_pkg::wb_addr_t'(xfcp_wb_pkg::WORD_BYTES);
                    rdy_val = 1'b1;
                    if (count_q != '0) begin
                        state_d = xfcp_wb_pkg::ST_WRITE_TAKE;
                    end else begin
                        rdy_own = !last_d;
                        state_d = last_d ? xfcp_wb_pkg::ST_IDLE : xfcp_wb_pkg::ST_DROP;
                    end
                end
            end

            xfcp_wb_pkg::ST_ID_SEND: begin
                rdy_own = 1'b1;
                rdy_val = !last_d;
                if (tx_ready_q) begin
                    tx.tvalid = 1'b1;
                    tx.tdata = xfcp_wb_pkg::ID_ROM[id_ptr_q];
                    id_ptr_d = id_ptr_q + 1'b1;
                    if (32'(id_ptr_q) == xfcp_wb_pkg::ID_LEN - 1) begin
                        tx.tlast = 1'b1;
                        rdy_own = !last_d;
                        state_d = last_d ? xfcp_wb_pkg::ST_IDLE : xfcp_wb_pkg::ST_DROP;
                    end
                end
            end

            default: begin
                // drop the rest of the packet
                rdy_own = 1'b1;
                if (in_fire && in_tlast_i) begin
                    rdy_own = 1'b0;
                    state_d = xfcp_wb_pkg::ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= xfcp_wb_pkg::ST_IDLE;
            in_ready_q <= 1'b0;
            tx_ready_q <= 1'b0;
            last_q <= 1'b0;
        end else begin
            state_q <= state_d;
            in_ready_q <= in_ready_d;
            tx_ready_q <= tx.tready_early;
            last_q <= last_d;
        end
        hdr_cnt_q <= hdr_cnt_d;
        id_ptr_q <= id_ptr_d;
        lane_q <= lane_d;
        we_q <= we_d;
        addr_q <= addr_d;
        count_q <= count_d;
        data_q <= data_d;
        sel_q <= sel_d;
    end

    // a byte is only offered when the skid register promised room
    tx_valid_needs_ready: assert property (
        @(posedge clk) disable iff (rst) tx.tvalid |-> tx_ready_q
    );

endmodule

// File: hw/xfcp_stream_if.sv
`timescale 1ns/1ns

interface xfcp_stream_if;
    xfcp_wb_pkg::byte_t tdata;
    logic               tvalid;
    logic               tlast;
    logic               tuser;
    logic               tready_early;

    // packet controller side
    modport src (
        output tdata, tvalid, tlast, tuser,
        input  tready_early
    );

    // output skid register side
    modport dst (
        input  tdata, tvalid, tlast, tuser,
        output tready_early
    );
endinterface

// File: hw/xfcp_tx_skid.sv
`timescale 1ns/1ns

module xfcp_tx_skid (
    input  logic               clk,
    input  logic               rst,
    xfcp_stream_if.dst         tx,
    output xfcp_wb_pkg::byte_t out_tdata_o,
    output logic               out_tvalid_o,
    output logic               out_tlast_o,
    output logic               out_tuser_o,
    input  logic               out_tready_i
);

    logic out_valid_q, out_valid_d;
    logic tmp_valid_q, tmp_valid_d;
    // user, last and data packed together
    logic [9:0] in_beat, out_beat_q, tmp_beat_q;
    logic load_out, load_tmp, move_tmp;

    assign in_beat = {tx.tuser, tx.tlast, tx.tdata};
    assign out_tdata_o = out_beat_q[7:0];
    assign out_tlast_o = out_beat_q[8];
    assign out_tuser_o = out_beat_q[9];
    assign out_tvalid_o = out_valid_q;

    // room next cycle unless the temp entry is about to fill
    assign tx.tready_early = out_tready_i || (!tmp_valid_q && (!out_valid_q || !tx.tvalid));

    always_comb begin
        out_valid_d = out_valid_q;
        tmp_valid_d = tmp_valid_q;
        load_out = 1'b0;
        load_tmp = 1'b0;
        move_tmp = 1'b0;
        if (tx.tvalid) begin
            if (out_tready_i || !out_valid_q) begin
                out_valid_d = 1'b1;
                load_out = 1'b1;
            end else begin
                tmp_valid_d = 1'b1;
                load_tmp = 1'b1;
            end
        end else if (out_tready_i) begin
            out_valid_d = tmp_valid_q;
            tmp_valid_d = 1'b0;
            move_tmp = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
            tmp_valid_q <= 1'b0;
        end else begin
            out_valid_q <= out_valid_d;
            tmp_valid_q <= tmp_valid_d;
        end
        if (load_out) begin
            out_beat_q <= in_beat;
        end else if (move_tmp) begin
            out_beat_q <= tmp_beat_q;
        end
        if (load_tmp) begin
            tmp_beat_q <= in_beat;
        end
    end

    out_holds_when_stalled: assert property (
        @(posedge clk) disable iff (rst)
        out_tvalid_o && !out_tready_i |=> out_tvalid_o && $stable(out_beat_q)
    );

endmodule

// File: hw/xfcp_wb_bridge.sv
`timescale 1ns/1ns

module xfcp_wb_bridge (
    input  logic                  clk,
    input  logic                  rst,
    input  xfcp_wb_pkg::byte_t    in_tdata_i,
    input  logic                  in_tvalid_i,
    input  logic                  in_tlast_i,
    output logic                  in_tready_o,
    output xfcp_wb_pkg::byte_t    out_tdata_o,
    output logic                  out_tvalid_o,
    output logic                  out_tlast_o,
    output logic                  out_tuser_o,
    input  logic                  out_tready_i,
    output xfcp_wb_pkg::wb_addr_t wb_adr_o,
    output xfcp_wb_pkg::wb_data_t wb_dat_o,
    input  xfcp_wb_pkg::wb_data_t wb_dat_i,
    output logic                  wb_we_o,
    output xfcp_wb_pkg::wb_sel_t  wb_sel_o,
    output logic                  wb_stb_o,
    output logic                  wb_cyc_o,
    input  logic                  wb_ack_i,
    input  logic                  wb_err_i
);

    xfcp_stream_if tx_if ();
    wb_req_if      req_if ();

    xfcp_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .in_tdata_i  (in_tdata_i),
        .in_tvalid_i (in_tvalid_i),
        .in_tlast_i  (in_tlast_i),
        .in_tready_o (in_tready_o),
        .tx          (tx_if),
        .wb          (req_if)
    );

    wb_access u_wb_access (
        .clk      (clk),
        .rst      (rst),
        .wb       (req_if),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_dat_i (wb_dat_i),
        .wb_we_o  (wb_we_o),
        .wb_sel_o (wb_sel_o),
        .wb_stb_o (wb_stb_o),
        .wb_cyc_o (wb_cyc_o),
        .wb_ack_i (wb_ack_i),
        .wb_err_i (wb_err_i)
    );

    xfcp_tx_skid u_tx_skid (
        .clk          (clk),
        .rst          (rst),
        .tx           (tx_if),
        .out_tdata_o  (out_tdata_o),
        .out_tvalid_o (out_tvalid_o),
        .out_tlast_o  (out_tlast_o),
        .out_tuser_o  (out_tuser_o),
        .out_tready_i (out_tready_i)
    );

endmodule

// File: hw/xfcp_wb_pkg.sv
package xfcp_wb_pkg;

    localparam int ADDR_BYTES  = 4;
    localparam int COUNT_BYTES = 2;
    localparam int WORD_BYTES  = 4;
    localparam int ID_LEN      = 32;

    typedef logic [7:0]               byte_t;
    typedef logic [8*ADDR_BYTES-1:0]  wb_addr_t;
    typedef logic [8*WORD_BYTES-1:0]  wb_data_t;
    typedef logic [WORD_BYTES-1:0]    wb_sel_t;
    typedef logic [8*COUNT_BYTES-1:0] count_t;

    // packet framing and type codes
    localparam byte_t START_TAG  = 8'hFE;
    localparam byte_t READ_REQ   = 8'h10;
    localparam byte_t READ_RESP  = 8'h11;
    localparam byte_t WRITE_REQ  = 8'h12;
    localparam byte_t WRITE_RESP = 8'h13;
    localparam byte_t ID_REQ     = 8'h01;
    localparam byte_t ID_RESP    = 8'h02;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_TYPE,
        ST_HEADER,
        ST_READ_WAIT,
        ST_READ_SEND,
        ST_WRITE_TAKE,
        ST_WRITE_WAIT,
        ST_ID_SEND,
        ST_DROP
    } ctrl_state_t;

    // widths as 16-bit little endian fields, then the name from byte 16
    localparam byte_t ID_ROM [ID_LEN] = '{
        8'h00, 8'h00,
        8'h20, 8'h00,
        8'h20, 8'h00,
        8'h08, 8'h00,
        8'h10, 8'h00,
        8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
        "X", "F", "C", "P", " ", "W", "B", " ",
        "B", "r", "i", "d", "g", "e", 8'h00, 8'h00
    };

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_xfcp_wb_bridge -f xfcp_wb_bridge.f -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_xfcp_wb_bridge > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: sim/tb_xfcp_wb_bridge.sv
`timescale 1ns/1ns

module tb_xfcp_wb_bridge;

    localparam int SEED          = 89203;
    localparam int READY_TIMEOUT = 2000;
    localparam int RESP_TIMEOUT  = 4000;

    logic                  clk;
    logic                  rst;
    xfcp_wb_pkg::byte_t    in_tdata_i;
    logic                  in_tvalid_i;
    logic                  in_tlast_i;
    logic                  in_tready_o;
    xfcp_wb_pkg::byte_t    out_tdata_o;
    logic                  out_tvalid_o;
    logic                  out_tlast_o;
    logic                  out_tuser_o;
    logic                  out_tready_i;
    xfcp_wb_pkg::wb_addr_t wb_adr_o;
    xfcp_wb_pkg::wb_data_t wb_dat_o;
    xfcp_wb_pkg::wb_data_t wb_dat_i;
    logic                  wb_we_o;
    xfcp_wb_pkg::wb_sel_t  wb_sel_o;
    logic                  wb_stb_o;
    logic                  wb_cyc_o;
    logic                  wb_ack_i;
    logic                  wb_err_i;

    // single random stream for stimulus and bus timing
    integer seed = SEED;

    xfcp_wb_pkg::byte_t    ref_mem [1024];
    xfcp_wb_pkg::wb_data_t wb_mem [256];

    // beats are kept as {tuser, tlast, tdata}
    xfcp_wb_pkg::byte_t pkt_q [$];
    logic [9:0]         exp_q [$];
    logic [9:0]         act_q [$];
    logic [9:0]         got_q [$];
    int got_rd = 0;
    int last_cnt = 0;
    int lasts_taken = 0;

    int    errors = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    test_errors_start = 0;
    string test_name;
    logic  aborted = 1'b0;

    xfcp_wb_bridge xfcp_wb_bridge_i (
        .clk          (clk),
        .rst          (rst),
        .in_tdata_i   (in_tdata_i),
        .in_tvalid_i  (in_tvalid_i),
        .in_tlast_i   (in_tlast_i),
        .in_tready_o  (in_tready_o),
        .out_tdata_o  (out_tdata_o),
        .out_tvalid_o (out_tvalid_o),
        .out_tlast_o  (out_tlast_o),
        .out_tuser_o  (out_tuser_o),
        .out_tready_i (out_tready_i),
        .wb_adr_o     (wb_adr_o),
        .wb_dat_o     (wb_dat_o),
        .wb_dat_i     (wb_dat_i),
        .wb_we_o      (wb_we_o),
        .wb_sel_o     (wb_sel_o),
        .wb_stb_o     (wb_stb_o),
        .wb_cyc_o     (wb_cyc_o),
        .wb_ack_i     (wb_ack_i),
        .wb_err_i     (wb_err_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // initial memory contents depend on every address bit
    function automatic xfcp_wb_pkg::byte_t fill_byte(input int a);
        logic [31:0] v;
        v = 32'(a) ^ (32'(a) >> 2) ^ 32'h3c;
        return v[7:0];
    endfunction

    // identity bytes with address, data, word and count widths before the name
    function automatic xfcp_wb_pkg::byte_t id_byte(input int i);
        case (i)
            2, 4: return 8'd32;
            6: return 8'd8;
            8: return 8'd16;
            default: return (i < 16) ? 8'h00 : xfcp_wb_pkg::ID_ROM[5'(i)];
        endcase
    endfunction

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // output back-pressure, response capture and the wishbone memory
    initial begin : bus_model
        logic [31:0] rnd;
        logic [7:0]  idx;
        logic        pending;
        int          delay;
        int          w;
        int          l;
        out_tready_i = 1'b0;
        wb_dat_i = '0;
        wb_ack_i = 1'b0;
        wb_err_i = 1'b0;
        pending = 1'b0;
        delay = 0;
        for (w = 0; w < 256; w++) begin
            for (l = 0; l < 4; l++) begin
                wb_mem[8'(w)][8*l +: 8] = fill_byte(4 * w + l);
            end
        end
        forever begin
            @(negedge clk);
            rnd = $random(seed);
            // low in about a third of cycles
            out_tready_i = (rnd % 32'd3) != 32'd0;
            // valid and ready now hold until the rising edge that takes the byte
            if (out_tvalid_o && out_tready_i) begin
                got_q.push_back({out_tuser_o, out_tlast_o, out_tdata_o});
                if (out_tlast_o) begin
                    last_cnt++;
                end
            end
            if (wb_ack_i) begin
                wb_ack_i = 1'b0;
            end else if (wb_cyc_o && wb_stb_o) begin
                if (!pending) begin
                    rnd = $random(seed);
                    delay = int'(rnd % 32'd4);
                    pending = 1'b1;
                end
                if (delay == 0) begin
                    idx = wb_adr_o[9:2];
                    if (wb_we_o) begin
                        for (l = 0; l < 4; l++) begin
                            if (wb_sel_o[2'(l)]) begin
                                wb_mem[idx][8*l +: 8] = wb_dat_o[8*l +: 8];
                            end
                        end
                    end
                    wb_dat_i = wb_mem[idx];
                    wb_ack_i = 1'b1;
                    pending = 1'b0;
                end else begin
                    delay--;
                end
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors_start = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors_start) begin
            $display("test %s finished, no errors", test_name);
            tests_passed++;
        end else begin
            $display("test %s finished, %0d errors", test_name, errors - test_errors_start);
            tests_failed++;
        end
    endtask

    task automatic push_expected(input xfcp_wb_pkg::byte_t data, input logic last,
                                 input logic user);
        exp_q.push_back({user, last, data});
    endtask

    task automatic send_packet(input string name);
        int i;
        int waited;
        if (aborted) begin
            return;
        end
        for (i = 0; i < pkt_q.size(); i++) begin
            @(negedge clk);
            in_tdata_i = pkt_q[i];
            in_tvalid_i = 1'b1;
            in_tlast_i = (i == pkt_q.size() - 1);
            waited = 0;
            // the registered ready stays put through the next rising edge
            while (!in_tready_o && waited < READY_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!in_tready_o) begin
                $display("timeout: in_tready_o stayed low while sending %s", name);
                errors++;
                aborted = 1'b1;
                break;
            end
        end
        @(negedge clk);
        in_tvalid_i = 1'b0;
        in_tlast_i = 1'b0;
    endtask

    task automatic wait_response(input string name);
        int waited;
        logic [9:0] beat;
        act_q.delete();
        if (aborted) begin
            return;
        end
        waited = 0;
        @(posedge clk);
        while (last_cnt == lasts_taken && waited < RESP_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (last_cnt == lasts_taken) begin
            $display("timeout: the response to %s never ended with tlast", name);
            errors++;
            aborted = 1'b1;
        end else begin
            do begin
                beat = got_q[got_rd];
                got_rd++;
                act_q.push_back(beat);
            end while (!beat[8]);
            lasts_taken++;
        end
    endtask

    task automatic compare_response(input string name);
        int i;
        check_value({name, " length"}, 32'(exp_q.size()), 32'(act_q.size()));
        for (i = 0; i < exp_q.size() && i < act_q.size(); i++) begin
            check_value($sformatf("%s byte %0d", name, i), 32'(exp_q[i]), 32'(act_q[i]));
        end
    endtask

    task automatic run_transaction(input string name);
        send_packet(name);
        wait_response(name);
        if (!aborted) begin
            compare_response(name);
        end
    endtask

    task automatic request_header(input xfcp_wb_pkg::byte_t req, input int addr, input int len);
        xfcp_wb_pkg::wb_addr_t a;
        xfcp_wb_pkg::count_t   c;
        a = xfcp_wb_pkg::wb_addr_t'(addr);
        c = xfcp_wb_pkg::count_t'(len);
        pkt_q.delete();
        exp_q.delete();
        pkt_q.push_back(xfcp_wb_pkg::START_TAG);
        pkt_q.push_back(req);
        // address and count both go msb first
        pkt_q.push_back(a[31:24]);
        pkt_q.push_back(a[23:16]);
        pkt_q.push_back(a[15:8]);
        pkt_q.push_back(a[7:0]);
        pkt_q.push_back(c[15:8]);
        pkt_q.push_back(c[7:0]);
    endtask

    // tag, response type and the six header bytes
    task automatic expect_echo(input xfcp_wb_pkg::byte_t resp, input logic last);
        int i;
        push_expected(xfcp_wb_pkg::START_TAG, 1'b0, 1'b0);
        push_expected(resp, 1'b0, 1'b0);
        for (i = 2; i < 8; i++) begin
            push_expected(pkt_q[i], last && i == 7, 1'b0);
        end
    endtask

    task automatic write_request(input string name, input int addr, input int len);
        int i;
        logic [31:0] rnd;
        request_header(xfcp_wb_pkg::WRITE_REQ, addr, len);
        expect_echo(xfcp_wb_pkg::WRITE_RESP, 1'b1);
        for (i = 0; i < len; i++) begin
            rnd = next_random();
            pkt_q.push_back(rnd[7:0]);
            ref_mem[10'(addr + i)] = rnd[7:0];
        end
        run_transaction(name);
    endtask

    task automatic read_request(input string name, input int addr, input int len);
        int i;
        request_header(xfcp_wb_pkg::READ_REQ, addr, len);
        expect_echo(xfcp_wb_pkg::READ_RESP, 1'b0);
        for (i = 0; i < len; i++) begin
            push_expected(ref_mem[10'(addr + i)], i == len - 1, 1'b0);
        end
        run_transaction(name);
    endtask

    task automatic identify_request(input string name);
        int i;
        pkt_q.delete();
        exp_q.delete();
        pkt_q.push_back(xfcp_wb_pkg::START_TAG);
        pkt_q.push_back(xfcp_wb_pkg::ID_REQ);
        push_expected(xfcp_wb_pkg::START_TAG, 1'b0, 1'b0);
        push_expected(xfcp_wb_pkg::ID_RESP, 1'b0, 1'b0);
        for (i = 0; i < 32; i++) begin
            push_expected(id_byte(i), i == 31, 1'b0);
        end
        run_transaction(name);
    endtask

    initial begin
        int a;
        int n;
        int base;
        int off;
        int len;
        logic [31:0] kind;
        rst = 1'b1;
        in_tdata_i = '0;
        in_tvalid_i = 1'b0;
        in_tlast_i = 1'b0;
        for (a = 0; a < 1024; a++) begin
            ref_mem[10'(a)] = fill_byte(a);
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;

        begin_test("identify");
        identify_request("identify");
        end_test();

        begin_test("aligned write and read");
        for (n = 0; n < 20; n++) begin
            base = int'(next_random() % 32'd240) * 4;
            len = int'(next_random() % 32'd16) + 1;
            write_request($sformatf("aligned write %0d", n), base, len);
            read_request($sformatf("aligned read %0d", n), base, len);
        end
        end_test();

        // read back the whole word span plus one more word
        begin_test("unaligned partial write");
        for (n = 0; n < 12; n++) begin
            base = int'(next_random() % 32'd240) * 4;
            off = int'(next_random() % 32'd3) + 1;
            len = int'(next_random() % 32'd8) + 1;
            write_request($sformatf("unaligned write %0d", n), base + off, len);
            read_request($sformatf("unaligned read %0d", n), base, off + len + 4);
        end
        end_test();

        begin_test("malformed packets");
        pkt_q.delete();
        pkt_q.push_back(xfcp_wb_pkg::START_TAG);
        pkt_q.push_back(8'h55);
        send_packet("unknown type");
        wait_response("unknown type");
        if (!aborted) begin
            check_value("unknown type length", 32'd2, 32'(act_q.size()));
            if (act_q.size() == 2) begin
                check_value("unknown type first byte", 32'(xfcp_wb_pkg::START_TAG),
                            32'(act_q[0]));
                check_value("unknown type tuser and tlast", 32'd3, 32'(act_q[1][9:8]));
            end
        end
        // cut after two address bytes
        pkt_q.delete();
        exp_q.delete();
        pkt_q.push_back(xfcp_wb_pkg::START_TAG);
        pkt_q.push_back(xfcp_wb_pkg::READ_REQ);
        pkt_q.push_back(8'h00);
        pkt_q.push_back(8'h01);
        push_expected(xfcp_wb_pkg::START_TAG, 1'b0, 1'b0);
        push_expected(xfcp_wb_pkg::READ_RESP, 1'b0, 1'b0);
        push_expected(8'h00, 1'b0, 1'b0);
        push_expected(8'h01, 1'b1, 1'b1);
        run_transaction("cut header");
        // bad start byte is dropped without any reply
        pkt_q.delete();
        pkt_q.push_back(8'h55);
        pkt_q.push_back(xfcp_wb_pkg::READ_REQ);
        pkt_q.push_back(8'h00);
        send_packet("bad start");
        identify_request("identify after bad start");
        end_test();

        begin_test("random mix");
        for (n = 0; n < 40; n++) begin
            kind = next_random() % 32'd3;
            base = int'(next_random() % 32'd1000);
            len = int'(next_random() % 32'd16) + 1;
            if (kind == 32'd0) begin
                read_request($sformatf("mix %0d read", n), base, len);
            end else if (kind == 32'd1) begin
                write_request($sformatf("mix %0d write", n), base, len);
            end else begin
                identify_request($sformatf("mix %0d identify", n));
            end
        end
        end_test();

        if (!aborted) begin
            check_value("stray response bytes", 32'd0, 32'(got_q.size() - got_rd));
        end
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: xfcp_wb_bridge.f
hw/xfcp_wb_pkg.sv
hw/xfcp_stream_if.sv
hw/wb_req_if.sv
hw/xfcp_ctrl.sv
hw/wb_access.sv
hw/xfcp_tx_skid.sv
hw/xfcp_wb_bridge.sv
sim/tb_xfcp_wb_bridge.sv
